/* rtl/wasm_conv_pkg.sv */
// WebAssembly conversion unit
// Shared types and IEEE constants

package wasm_conv_pkg;

    // Operand, result and float bit patterns
    typedef logic [63:0] word_t;
    typedef logic [31:0] f32_bits_t;
    typedef logic [63:0] f64_bits_t;

    // Conversion opcode bytes handled by the unit
    typedef enum logic [7:0] {
        OP_I32_WRAP_I64        = 8'hA7,
        OP_I32_TRUNC_F32_S     = 8'hA8,
        OP_I32_TRUNC_F32_U     = 8'hA9,
        OP_I32_TRUNC_F64_S     = 8'hAA,
        OP_I32_TRUNC_F64_U     = 8'hAB,
        OP_I64_EXTEND_I32_S    = 8'hAC,
        OP_I64_EXTEND_I32_U    = 8'hAD,
        OP_I64_TRUNC_F32_S     = 8'hAE,
        OP_I64_TRUNC_F32_U     = 8'hAF,
        OP_I64_TRUNC_F64_S     = 8'hB0,
        OP_I64_TRUNC_F64_U     = 8'hB1,
        OP_F32_DEMOTE_F64      = 8'hB6,
        OP_F64_PROMOTE_F32     = 8'hBB,
        OP_I32_REINTERPRET_F32 = 8'hBC,
        OP_I64_REINTERPRET_F64 = 8'hBD,
        OP_F32_REINTERPRET_I32 = 8'hBE,
        OP_F64_REINTERPRET_I64 = 8'hBF,
        OP_I32_EXTEND8_S       = 8'hC0,
        OP_I32_EXTEND16_S      = 8'hC1,
        OP_I64_EXTEND8_S       = 8'hC2,
        OP_I64_EXTEND16_S      = 8'hC3,
        OP_I64_EXTEND32_S      = 8'hC4,
        OP_PREFIX_FC           = 8'hFC
    } opcode_t;

    // Saturating truncations behind the 0xFC prefix
    // bit 0 unsigned, bit 1 f64 source, bit 2 i64 destination
    typedef enum logic [7:0] {
        SAT_I32_F32_S = 8'h00,
        SAT_I32_F32_U = 8'h01,
        SAT_I32_F64_S = 8'h02,
        SAT_I32_F64_U = 8'h03,
        SAT_I64_F32_S = 8'h04,
        SAT_I64_F32_U = 8'h05,
        SAT_I64_F64_S = 8'h06,
        SAT_I64_F64_U = 8'h07
    } sat_op_t;

    typedef enum logic [1:0] {
        TRAP_NONE         = 2'd0,
        TRAP_INVALID_CONV = 2'd1
    } trap_t;

    // IEEE 754 field widths
    localparam int F32_EXP_W  = 8;
    localparam int F32_MANT_W = 23;
    localparam int F64_EXP_W  = 11;
    localparam int F64_MANT_W = 52;

    // Exponent biases
    localparam int F32_BIAS   = 127;
    localparam int F64_BIAS   = 1023;
    localparam int BIAS_DELTA = F64_BIAS - F32_BIAS;

    // Canonical quiet NaNs
    localparam f32_bits_t F32_CANON_NAN = 32'h7FC0_0000;
    localparam f64_bits_t F64_CANON_NAN = 64'h7FF8_0000_0000_0000;

endpackage

/* rtl/int_resize.sv */
// Integer resize and reinterpretation

`timescale 1ns/1ps

module int_resize (
    input  wasm_conv_pkg::opcode_t op,
    input  wasm_conv_pkg::word_t   operand,
    output wasm_conv_pkg::word_t   result
);

    import wasm_conv_pkg::*;

    always_comb begin
        case (op)
            // Low word only, upper half cleared
            OP_I32_WRAP_I64,
            OP_I64_EXTEND_I32_U,
            OP_I32_REINTERPRET_F32,
            OP_F32_REINTERPRET_I32: begin
                result = {32'h0, operand[31:0]};
            end

            OP_I64_EXTEND_I32_S,
            OP_I64_EXTEND32_S: begin
                result = {{32{operand[31]}}, operand[31:0]};
            end

            // i32 forms carry their sign through the full word
            OP_I32_EXTEND8_S,
            OP_I64_EXTEND8_S: begin
                result = {{56{operand[7]}}, operand[7:0]};
            end

            OP_I32_EXTEND16_S,
            OP_I64_EXTEND16_S: begin
                result = {{48{operand[15]}}, operand[15:0]};
            end

            // Bit patterns pass unchanged
            OP_I64_REINTERPRET_F64,
            OP_F64_REINTERPRET_I64: begin
                result = operand;
            end

            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* rtl/float_resize.sv */
// Float promotion and demotion

`timescale 1ns/1ps

module float_resize (
    input  wasm_conv_pkg::f32_bits_t f32_in,
    input  wasm_conv_pkg::f64_bits_t f64_in,
    output wasm_conv_pkg::f64_bits_t promoted,
    output wasm_conv_pkg::f32_bits_t demoted
);

    import wasm_conv_pkg::*;

    // Promotion side
    logic                  p_sign;
    logic [F32_EXP_W-1:0]  p_exp;
    logic [F32_MANT_W-1:0] p_mant;
    logic [4:0]            p_lead;
    logic [4:0]            p_shift;
    logic [F32_MANT_W-1:0] p_frac;

    // Demotion side
    logic                  d_sign;
    logic [F64_EXP_W-1:0]  d_exp;
    logic [F64_MANT_W-1:0] d_mant;
    logic [F64_MANT_W:0]   d_sig;
    logic [5:0]            sub_sh;
    logic [F64_MANT_W:0]   sub_q;
    logic [F64_MANT_W:0]   sub_mask;
    logic [30:0]           pre_round;
    logic                  rnd_g;
    logic                  rnd_s;
    logic                  round_up;
    logic [30:0]           rounded;

    assign {p_sign, p_exp, p_mant} = f32_in;
    assign {d_sign, d_exp, d_mant} = f64_in;
    assign d_sig = {1'b1, d_mant};

    always_comb begin
        // Highest set bit of a subnormal f32 fraction
        p_lead = '0;
        for (int i = 0; i < F32_MANT_W; i++) begin
            if (p_mant[i]) begin
                p_lead = 5'(i);
            end
        end
        // Shift that pushes the leading one into the hidden position
        p_shift = 5'(F32_MANT_W) - p_lead;
        p_frac  = p_mant << p_shift;

        if (p_exp == '1) begin
            if (p_mant != '0) begin
                promoted = F64_CANON_NAN;
            end else begin
                promoted = {p_sign, {F64_EXP_W{1'b1}}, {F64_MANT_W{1'b0}}};
            end
        end else if (p_exp == '0) begin
            if (p_mant == '0) begin
                promoted = {p_sign, {(F64_EXP_W + F64_MANT_W){1'b0}}};
            end else begin
                promoted = {p_sign, 11'(BIAS_DELTA + 1) - 11'(p_shift), p_frac,
                            {(F64_MANT_W - F32_MANT_W){1'b0}}};
            end
        end else begin
            promoted = {p_sign, 11'(p_exp) + 11'(BIAS_DELTA), p_mant,
                        {(F64_MANT_W - F32_MANT_W){1'b0}}};
        end
    end

    always_comb begin
        sub_sh    = '0;
        sub_q     = '0;
        sub_mask  = '0;
        pre_round = '0;
        rnd_g     = 1'b0;
        rnd_s     = 1'b0;

        if (d_exp >= 11'(BIAS_DELTA + 1)) begin
            // Normal f32 range, drop the low 29 fraction bits
            pre_round = {8'(d_exp - 11'(BIAS_DELTA)),
                         d_mant[F64_MANT_W-1 -: F32_MANT_W]};
            rnd_g = d_mant[F64_MANT_W-F32_MANT_W-1];
            rnd_s = |d_mant[F64_MANT_W-F32_MANT_W-2:0];
        end else if (d_exp >= 11'(BIAS_DELTA - F32_MANT_W)) begin
            // Subnormal range, shift of 30 to 53 with the hidden one included
            sub_sh    = 6'(11'(BIAS_DELTA + F64_MANT_W - F32_MANT_W + 1) - d_exp);
            sub_q     = d_sig >> sub_sh;
            sub_mask  = (53'd1 << (sub_sh - 6'd1)) - 53'd1;
            pre_round = {8'h00, sub_q[F32_MANT_W-1:0]};
            rnd_g     = d_sig[sub_sh - 6'd1];
            rnd_s     = |(d_sig & sub_mask);
        end

        // Nearest-even; a fraction carry moves into the exponent field
        round_up = rnd_g & (rnd_s | pre_round[0]);
        rounded  = pre_round + 31'(round_up);

        if (d_exp == '1 && d_mant != '0) begin
            demoted = F32_CANON_NAN;
        end else if (d_exp > 11'(F64_BIAS + F32_BIAS)) begin
            demoted = {d_sign, {F32_EXP_W{1'b1}}, {F32_MANT_W{1'b0}}};
        end else begin
            demoted = {d_sign, rounded};
        end
    end

endmodule

/* rtl/float_trunc.sv */
// Float to integer truncation

`timescale 1ns/1ps

module float_trunc (
    input  wasm_conv_pkg::f64_bits_t value,
    input  logic                     to_i64,
    input  logic                     is_signed,
    input  logic                     saturate,
    output wasm_conv_pkg::word_t     result,
    output logic                     invalid
);

    import wasm_conv_pkg::*;

    logic                     sign;
    logic [F64_EXP_W-1:0]     exp_f;
    logic [F64_MANT_W-1:0]    mant;
    logic [F64_MANT_W:0]      sig;
    logic [5:0]               sh;
    logic [F64_MANT_W+63:0]   shifted;
    word_t                    mag;
    word_t                    signed_val;
    word_t                    in_range;
    word_t                    max_val;
    word_t                    min_val;
    logic                     is_nan;
    logic                     ge_one;
    logic                     ge_w;
    logic                     at_edge;
    logic                     edge_frac;
    logic                     pos_ovf;
    logic                     neg_ovf;

    assign {sign, exp_f, mant} = value;
    assign sig = {1'b1, mant};

    // Integer part of the magnitude, binary point after bit 52 of sig
    assign sh      = 6'(exp_f - 11'(F64_BIAS));
    assign shifted = {{63{1'b0}}, sig} << sh;
    assign ge_one  = exp_f >= 11'(F64_BIAS);
    assign mag     = ge_one ? shifted[F64_MANT_W+63:F64_MANT_W] : '0;

    assign signed_val = sign ? -mag : mag;

    always_comb begin
        if (to_i64) begin
            in_range = signed_val;
        end else if (is_signed) begin
            in_range = {{32{signed_val[31]}}, signed_val[31:0]};
        end else begin
            in_range = {32'h0, signed_val[31:0]};
        end
    end

    // Range from exponent and sign; at 2^(W-1) only an exact minimum fits
    assign is_nan    = (exp_f == '1) && (mant != '0);
    assign ge_w      = to_i64 ? (exp_f >= 11'(F64_BIAS + 64)) : (exp_f >= 11'(F64_BIAS + 32));
    assign at_edge   = to_i64 ? (exp_f == 11'(F64_BIAS + 63)) : (exp_f == 11'(F64_BIAS + 31));
    assign edge_frac = to_i64 ? (|mag[62:0]) : (|mag[30:0]);

    always_comb begin
        if (is_signed) begin
            pos_ovf = !sign && (ge_w || at_edge);
            neg_ovf = sign && (ge_w || (at_edge && edge_frac));
        end else begin
            pos_ovf = !sign && ge_w;
            // Anything at or below -1.0
            neg_ovf = sign && ge_one;
        end
    end

    always_comb begin
        case ({to_i64, is_signed})
            2'b00: begin
                max_val = 64'h0000_0000_FFFF_FFFF;
                min_val = '0;
            end
            2'b01: begin
                max_val = 64'h0000_0000_7FFF_FFFF;
                min_val = 64'hFFFF_FFFF_8000_0000;
            end
            2'b10: begin
                max_val = '1;
                min_val = '0;
            end
            default: begin
                max_val = 64'h7FFF_FFFF_FFFF_FFFF;
                min_val = 64'h8000_0000_0000_0000;
            end
        endcase
    end

    always_comb begin
        invalid = 1'b0;
        result  = in_range;
        if (saturate) begin
            if (is_nan) begin
                result = '0;
            end else if (pos_ovf) begin
                result = max_val;
            end else if (neg_ovf) begin
                result = min_val;
            end
        end else if (is_nan || pos_ovf || neg_ovf) begin
            invalid = 1'b1;
            result  = '0;
        end
    end

    // Saturating forms clamp and never trap
    always_comb begin
        assert (!(saturate && invalid))
            else $error("float_trunc: invalid raised in saturating mode");
    end

endmodule

/* rtl/wasm_conv.sv */
// WebAssembly numeric conversion unit

`timescale 1ns/1ps

module wasm_conv (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   valid_in,
    input  wasm_conv_pkg::opcode_t op,
    input  logic [7:0]             sub_op,
    input  wasm_conv_pkg::word_t   operand,
    output logic                   valid_out,
    output wasm_conv_pkg::word_t   result,
    output wasm_conv_pkg::trap_t   trap
);

    import wasm_conv_pkg::*;

    sat_op_t   sat_op;
    logic      is_int;
    logic      is_promote;
    logic      is_demote;
    logic      is_trunc;
    logic      src_f64;
    logic      to_i64;
    logic      is_signed;
    logic      saturate;
    word_t     int_result;
    f64_bits_t promoted;
    f32_bits_t demoted;
    f64_bits_t trunc_src;
    word_t     trunc_result;
    logic      trunc_invalid;
    word_t     next_result;
    trap_t     next_trap;

    assign sat_op = sat_op_t'(sub_op);

    // Opcode classification and truncation controls
    always_comb begin
        is_int     = 1'b0;
        is_promote = 1'b0;
        is_demote  = 1'b0;
        is_trunc   = 1'b0;
        src_f64    = 1'b0;
        to_i64     = 1'b0;
        is_signed  = 1'b0;
        saturate   = 1'b0;
        case (op)
            OP_I32_WRAP_I64, OP_I64_EXTEND_I32_S, OP_I64_EXTEND_I32_U,
            OP_I32_EXTEND8_S, OP_I32_EXTEND16_S, OP_I64_EXTEND8_S,
            OP_I64_EXTEND16_S, OP_I64_EXTEND32_S,
            OP_I32_REINTERPRET_F32, OP_I64_REINTERPRET_F64,
            OP_F32_REINTERPRET_I32, OP_F64_REINTERPRET_I64: begin
                is_int = 1'b1;
            end
            OP_F64_PROMOTE_F32: begin
                is_promote = 1'b1;
            end
            OP_F32_DEMOTE_F64: begin
                is_demote = 1'b1;
            end
            OP_I32_TRUNC_F32_S, OP_I32_TRUNC_F32_U, OP_I32_TRUNC_F64_S,
            OP_I32_TRUNC_F64_U, OP_I64_TRUNC_F32_S, OP_I64_TRUNC_F32_U,
            OP_I64_TRUNC_F64_S, OP_I64_TRUNC_F64_U: begin
                is_trunc  = 1'b1;
                src_f64   = op inside {OP_I32_TRUNC_F64_S, OP_I32_TRUNC_F64_U,
                                       OP_I64_TRUNC_F64_S, OP_I64_TRUNC_F64_U};
                to_i64    = op inside {OP_I64_TRUNC_F32_S, OP_I64_TRUNC_F32_U,
                                       OP_I64_TRUNC_F64_S, OP_I64_TRUNC_F64_U};
                is_signed = op inside {OP_I32_TRUNC_F32_S, OP_I32_TRUNC_F64_S,
                                       OP_I64_TRUNC_F32_S, OP_I64_TRUNC_F64_S};
            end
            OP_PREFIX_FC: begin
                // Sub-opcodes above 0x07 fall through as unsupported
                if (sub_op <= 8'h07) begin
                    is_trunc  = 1'b1;
                    saturate  = 1'b1;
                    src_f64   = sat_op inside {SAT_I32_F64_S, SAT_I32_F64_U,
                                               SAT_I64_F64_S, SAT_I64_F64_U};
                    to_i64    = sat_op inside {SAT_I64_F32_S, SAT_I64_F32_U,
                                               SAT_I64_F64_S, SAT_I64_F64_U};
                    is_signed = sat_op inside {SAT_I32_F32_S, SAT_I32_F64_S,
                                               SAT_I64_F32_S, SAT_I64_F64_S};
                end
            end
            default: begin
                is_int = 1'b0;
            end
        endcase
    end

    int_resize u_int_resize (
        .op      (op),
        .operand (operand),
        .result  (int_result)
    );

    float_resize u_float_resize (
        .f32_in   (operand[31:0]),
        .f64_in   (operand),
        .promoted (promoted),
        .demoted  (demoted)
    );

    // f32 sources reach truncation through the exact promotion
    assign trunc_src = src_f64 ? operand : promoted;

    float_trunc u_float_trunc (
        .value     (trunc_src),
        .to_i64    (to_i64),
        .is_signed (is_signed),
        .saturate  (saturate),
        .result    (trunc_result),
        .invalid   (trunc_invalid)
    );

    always_comb begin
        next_result = '0;
        next_trap   = TRAP_NONE;
        if (is_int) begin
            next_result = int_result;
        end else if (is_promote) begin
            next_result = promoted;
        end else if (is_demote) begin
            next_result = {32'h0, demoted};
        end else if (is_trunc) begin
            next_result = trunc_result;
            if (trunc_invalid) begin
                next_trap = TRAP_INVALID_CONV;
            end
        end
    end

    // Output stage
    // Result holds between requests while trap only flags a live result
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
            result    <= '0;
            trap      <= TRAP_NONE;
        end else begin
            valid_out <= valid_in;
            if (valid_in) begin
                result <= next_result;
                trap   <= next_trap;
            end else begin
                trap   <= TRAP_NONE;
            end
        end
    end

    a_valid_after_reset: assert property (@(posedge clk) $rose(arst_n) |=> !valid_out);

    a_trap_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n) !valid_out |-> (trap == TRAP_NONE));

endmodule

/* tb/tb_wasm_conv.sv */
// Testbench for the conversion unit

`timescale 1ns/1ps

module tb_wasm_conv;

    import wasm_conv_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    logic    clk;
    logic    arst_n;
    logic    valid_in;
    opcode_t op;
    logic    [7:0] sub_op;
    word_t   operand;
    logic    valid_out;
    word_t   result;
    trap_t   trap;

    // Vectors as read from the data file
    logic [7:0]  vec_op[$];
    logic [7:0]  vec_sub[$];
    logic [63:0] vec_operand[$];
    logic [63:0] vec_result[$];
    logic [1:0]  vec_trap[$];

    int cycle_count;
    int cycle_limit;

    wasm_conv dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid_in),
        .op        (op),
        .sub_op    (sub_op),
        .operand   (operand),
        .valid_out (valid_out),
        .result    (result),
        .trap      (trap)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic expect_equal(input string what, input logic [63:0] got,
                                input logic [63:0] expected);
        if (got !== expected) begin
            stop_with_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                      $time, what, got, expected));
        end
    endtask

    // Lines that do not hold five hex fields are comments
    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  f_op;
        logic [7:0]  f_sub;
        logic [63:0] f_operand;
        logic [63:0] f_result;
        logic [7:0]  f_trap;
        fd = $fopen("tb/wasm_conv_testdata.hex", "r");
        if (fd == 0) begin
            stop_with_error("Cannot open the test data file tb/wasm_conv_testdata.hex");
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h",
                                 f_op, f_sub, f_operand, f_result, f_trap);
                if (fields == 5) begin
                    vec_op.push_back(f_op);
                    vec_sub.push_back(f_sub);
                    vec_operand.push_back(f_operand);
                    vec_result.push_back(f_result);
                    vec_trap.push_back(f_trap[1:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    // Run limit, set once the vector count is known
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_with_error($sformatf("Timeout: run exceeded %0d clock cycles", cycle_limit));
        end
    end

    initial begin
        void'($urandom(67715));
        arst_n      = 1'b0;
        valid_in    = 1'b0;
        op          = OP_I32_WRAP_I64;
        sub_op      = 8'h00;
        operand     = '0;
        cycle_count = 0;
        cycle_limit = 0;

        load_vectors();
        if (vec_op.size() == 0) begin
            stop_with_error("The test data file holds no vectors");
        end
        cycle_limit = 2 * vec_op.size() + 50;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            expect_equal("valid_out during reset", 64'(valid_out), 64'd0);
        end
        arst_n = 1'b1;
        @(negedge clk);
        expect_equal("valid_out after reset", 64'(valid_out), 64'd0);
        expect_equal("result after reset", result, 64'd0);
        expect_equal("trap after reset", 64'(trap), 64'(TRAP_NONE));

        foreach (vec_op[i]) begin
            valid_in = 1'b1;
            op       = opcode_t'(vec_op[i]);
            sub_op   = vec_sub[i];
            operand  = vec_operand[i];
            @(negedge clk);
            expect_equal($sformatf("vector %0d valid_out", i), 64'(valid_out), 64'd1);
            expect_equal($sformatf("vector %0d result", i), result, vec_result[i]);
            expect_equal($sformatf("vector %0d trap", i), 64'(trap), 64'(vec_trap[i]));
            valid_in = 1'b0;

            // Occasional gap between requests
            if ($urandom % 4 == 0) begin
                @(negedge clk);
                expect_equal($sformatf("idle after %0d valid_out", i), 64'(valid_out), 64'd0);
                expect_equal($sformatf("idle after %0d trap", i), 64'(trap),
                             64'(TRAP_NONE));
                expect_equal($sformatf("idle after %0d result", i), result, vec_result[i]);
            end
        end

        @(negedge clk);
        expect_equal("valid_out after last vector", 64'(valid_out), 64'd0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tb/wasm_conv_testdata.hex */
// op sub_op operand expected_result expected_trap, all hex
// trap 0 is none, 1 is invalid conversion
A7 00 123456789ABCDEF0 000000009ABCDEF0 0
AC 00 0000000080000001 FFFFFFFF80000001 0
AD 00 FFFFFFFF80000001 0000000080000001 0
C0 00 0000000012345680 FFFFFFFFFFFFFF80 0
C1 00 0000000000008000 FFFFFFFFFFFF8000 0
C2 00 AAAAAAAAAAAAAA7F 000000000000007F 0
C3 00 000000000000ABCD FFFFFFFFFFFFABCD 0
C4 00 00000000FEDCBA98 FFFFFFFFFEDCBA98 0
BC 00 FFFFFFFF3F800000 000000003F800000 0
BF 00 7FF8000000000001 7FF8000000000001 0
BB 00 000000003F800000 3FF0000000000000 0
BB 00 00000000C0490FDB C00921FB60000000 0
BB 00 0000000000000001 36A0000000000000 0
BB 00 00000000007FFFFF 380FFFFFC0000000 0
BB 00 000000007F800001 7FF8000000000000 0
BB 00 00000000FF800000 FFF0000000000000 0
B6 00 C00921FB54442D18 00000000C0490FDB 0
B6 00 3FF0000010000000 000000003F800000 0
B6 00 3FF0000030000000 000000003F800002 0
B6 00 3FFFFFFFFFFFFFFF 0000000040000000 0
B6 00 4800000000000000 000000007F800000 0
B6 00 47EFFFFFF0000000 000000007F800000 0
B6 00 36A8000000000000 0000000000000002 0
B6 00 380FFFFFFFFFFFFF 0000000000800000 0
B6 00 B370000000000000 0000000080000000 0
B6 00 7FF0000000000001 000000007FC00000 0
A8 00 00000000C0300000 FFFFFFFFFFFFFFFE 0
A8 00 000000004F000000 0000000000000000 1
A9 00 000000004F7FFFFF 00000000FFFFFF00 0
A9 00 00000000BF800000 0000000000000000 1
AA 00 C1E0000000100000 FFFFFFFF80000000 0
AA 00 C1E0000000200000 0000000000000000 1
AB 00 41EFFFFFFFF00000 00000000FFFFFFFF 0
AB 00 BFECCCCCCCCCCCCD 0000000000000000 0
AB 00 BFF0000000000000 0000000000000000 1
AE 00 00000000DF000000 8000000000000000 0
AE 00 000000007FC00000 0000000000000000 1
AF 00 000000005F800000 0000000000000000 1
B0 00 43DFFFFFFFFFFFFF 7FFFFFFFFFFFFC00 0
B0 00 FFF0000000000000 0000000000000000 1
B1 00 43EFFFFFFFFFFFFF FFFFFFFFFFFFF800 0
FC 00 000000004F000000 000000007FFFFFFF 0
FC 00 000000007FC00000 0000000000000000 0
FC 01 00000000BF800000 0000000000000000 0
FC 01 000000007F800000 00000000FFFFFFFF 0
FC 02 FFF0000000000000 FFFFFFFF80000000 0
FC 03 41F0000000000000 00000000FFFFFFFF 0
FC 04 000000005F000000 7FFFFFFFFFFFFFFF 0
FC 04 00000000FF800000 8000000000000000 0
FC 05 000000005F800000 FFFFFFFFFFFFFFFF 0
FC 06 C3E0000000000001 8000000000000000 0
FC 07 7FF0000000000000 FFFFFFFFFFFFFFFF 0
FC 07 BFF0000000000000 0000000000000000 0
B2 00 0000000000000005 0000000000000000 0
B9 00 4000000000000000 0000000000000000 0
FC 08 3FF0000000000000 0000000000000000 0

/* wasm_conv.f */
rtl/wasm_conv_pkg.sv
rtl/int_resize.sv
rtl/float_resize.sv
rtl/float_trunc.sv
rtl/wasm_conv.sv
tb/tb_wasm_conv.sv

/* Makefile */
SRCS := rtl/wasm_conv_pkg.sv rtl/int_resize.sv rtl/float_resize.sv \
        rtl/float_trunc.sv rtl/wasm_conv.sv tb/tb_wasm_conv.sv

.PHONY: all run clean

all: obj_dir/Vtb_wasm_conv

obj_dir/Vtb_wasm_conv: $(SRCS) wasm_conv.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_wasm_conv -f wasm_conv.f

run: obj_dir/Vtb_wasm_conv
	./obj_dir/Vtb_wasm_conv > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
